//--- rtl/mlse_static_config.svh
`ifndef MLSE_STATIC_CONFIG_SVH
`define MLSE_STATIC_CONFIG_SVH

// width of one branch value, energies are twice this
`define MLSE_B_WIDTH 8

// symbols decided per clock
`define MLSE_B_LEN 2

// surviving states presented by the trellis
`define MLSE_N_S 7

// global decided-symbol history length
`define MLSE_SH_DEPTH 12

// channel estimate taps and tap width
`define MLSE_CHAN_DEPTH 8
`define MLSE_CHAN_WIDTH 8

`endif

//--- rtl/mlse_static_pkg.sv
`include "mlse_static_config.svh"

package mlse_static_pkg;

    // decided symbol alphabet, two's complement coded
    typedef enum logic signed [1:0] {
        sym_minus = 2'b11,
        sym_zero  = 2'b00,
        sym_plus  = 2'b01
    } symbol_t;

    // accumulated path energy
    typedef logic [2*`MLSE_B_WIDTH-1:0] energy_t;

    // rse values, static values and their sums
    typedef logic signed [`MLSE_B_WIDTH-1:0] branch_val_t;

    // one estimated channel tap
    typedef logic signed [`MLSE_CHAN_WIDTH-1:0] tap_t;

    // index of a surviving state
    typedef logic [$clog2(`MLSE_N_S)-1:0] state_idx_t;

endpackage

//--- rtl/static_select_unit.sv
`timescale 1ns/1ps

`include "mlse_static_config.svh"

module static_select_unit (
    input  mlse_static_pkg::energy_t state_energies [`MLSE_N_S-1:0],
    input  mlse_static_pkg::symbol_t state_histories [`MLSE_N_S-1:0][`MLSE_B_LEN-1:0],

    output mlse_static_pkg::energy_t best_state_energy,
    output mlse_static_pkg::symbol_t best_state_history [`MLSE_B_LEN-1:0]
);

    // running minimum along the compare-select chain
    mlse_static_pkg::energy_t   run_energy [`MLSE_N_S-1:0];
    mlse_static_pkg::state_idx_t run_idx   [`MLSE_N_S-1:0];

    assign run_energy[0] = state_energies[0];
    assign run_idx[0]    = '0;

    genvar s;
    generate
        for (s = 1; s < `MLSE_N_S; s += 1) begin : g_cmp
            logic take;

            // strict less-than keeps the lower index on a tie
            assign take = state_energies[s] < run_energy[s-1];

            assign run_energy[s] = take ? state_energies[s] : run_energy[s-1];
            assign run_idx[s]    = take ? mlse_static_pkg::state_idx_t'(s) : run_idx[s-1];
        end
    endgenerate

    assign best_state_energy = run_energy[`MLSE_N_S-1];

    // symbol vector of the winning state
    genvar b;
    generate
        for (b = 0; b < `MLSE_B_LEN; b += 1) begin : g_hist
            assign best_state_history[b] = state_histories[run_idx[`MLSE_N_S-1]][b];
        end
    endgenerate

endmodule

//--- rtl/conv_unit.sv
`timescale 1ns/1ps

`include "mlse_static_config.svh"

module conv_unit (
    input  mlse_static_pkg::symbol_t    global_static_history [`MLSE_SH_DEPTH-1:0],
    input  mlse_static_pkg::tap_t       est_channel [`MLSE_CHAN_DEPTH-1:0],

    output mlse_static_pkg::branch_val_t static_val [`MLSE_B_LEN-1:0]
);

    // room for a full-scale sum of all taps plus one negated minimum tap
    localparam integer ACC_WIDTH = `MLSE_CHAN_WIDTH + $clog2(`MLSE_CHAN_DEPTH) + 1;

    logic signed [ACC_WIDTH-1:0] term [`MLSE_B_LEN-1:0][`MLSE_CHAN_DEPTH-1:0];

    genvar j, k;
    generate
        for (j = 0; j < `MLSE_B_LEN; j += 1) begin : g_branch
            logic signed [ACC_WIDTH-1:0] acc;

            for (k = 0; k < `MLSE_CHAN_DEPTH; k += 1) begin : g_tap
                if (j + `MLSE_B_LEN + k < `MLSE_SH_DEPTH) begin : g_live
                    logic signed [ACC_WIDTH-1:0] tap_ext;

                    assign tap_ext = ACC_WIDTH'(est_channel[k]);

                    // symbol is -1, 0 or +1 so the product is negate, pass or zero
                    assign term[j][k] =
                        (global_static_history[j+`MLSE_B_LEN+k] == mlse_static_pkg::sym_plus)
                            ? tap_ext :
                        (global_static_history[j+`MLSE_B_LEN+k] == mlse_static_pkg::sym_minus)
                            ? -tap_ext : '0;
                end else begin : g_past_end
                    // slot beyond the history counts as zero
                    assign term[j][k] = '0;
                end
            end

            always_comb begin
                acc = '0;
                for (int t = 0; t < `MLSE_CHAN_DEPTH; t += 1) begin
                    acc = acc + term[j][t];
                end
            end

            // only the final truncation wraps
            assign static_val[j] = mlse_static_pkg::branch_val_t'(acc);
        end
    endgenerate

endmodule

//--- rtl/static_history_unit.sv
`timescale 1ns/1ps

`include "mlse_static_config.svh"

module static_history_unit (
    input  logic                        clk,
    input  logic                        rst_n,

    input  mlse_static_pkg::energy_t    best_state_energy,
    input  mlse_static_pkg::symbol_t    best_state_history [`MLSE_B_LEN-1:0],
    input  mlse_static_pkg::branch_val_t static_val [`MLSE_B_LEN-1:0],
    input  mlse_static_pkg::branch_val_t rse_vals [`MLSE_B_LEN-1:0],

    output mlse_static_pkg::symbol_t    global_static_history [`MLSE_SH_DEPTH-1:0],
    output mlse_static_pkg::symbol_t    final_symbols [`MLSE_B_LEN-1:0],
    output mlse_static_pkg::branch_val_t precomputed_static_val [`MLSE_B_LEN-1:0],
    output mlse_static_pkg::energy_t    global_static_energy
);

    // slot 0 holds the newest symbol, each clock moves everything B_LEN slots older
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `MLSE_SH_DEPTH; i += 1) begin
                global_static_history[i] <= mlse_static_pkg::sym_zero;
            end
            global_static_energy <= '0;
        end else begin
            for (int i = `MLSE_B_LEN; i < `MLSE_SH_DEPTH; i += 1) begin
                global_static_history[i] <= global_static_history[i-`MLSE_B_LEN];
            end
            for (int i = 0; i < `MLSE_B_LEN; i += 1) begin
                global_static_history[i] <= best_state_history[i];
            end
            global_static_energy <= best_state_energy;
        end
    end

    genvar b;
    generate
        for (b = 0; b < `MLSE_B_LEN; b += 1) begin : g_out
            assign final_symbols[b] = global_static_history[b];

            // interference of decided symbols plus received-sample estimate, wrapped
            assign precomputed_static_val[b] =
                mlse_static_pkg::branch_val_t'(static_val[b] + rse_vals[b]);
        end
    endgenerate

endmodule

//--- rtl/global_static_unit.sv
`timescale 1ns/1ps

`include "mlse_static_config.svh"

module global_static_unit (
    input  logic                        clk,
    input  logic                        rst_n,

    input  mlse_static_pkg::energy_t    state_energies [`MLSE_N_S-1:0],
    input  mlse_static_pkg::symbol_t    state_histories [`MLSE_N_S-1:0][`MLSE_B_LEN-1:0],
    input  mlse_static_pkg::tap_t       est_channel [`MLSE_CHAN_DEPTH-1:0],
    input  mlse_static_pkg::branch_val_t rse_vals [`MLSE_B_LEN-1:0],

    output mlse_static_pkg::symbol_t    final_symbols [`MLSE_B_LEN-1:0],
    output mlse_static_pkg::branch_val_t precomputed_static_val [`MLSE_B_LEN-1:0],
    output mlse_static_pkg::energy_t    global_static_energy
);

    mlse_static_pkg::energy_t    best_state_energy;
    mlse_static_pkg::symbol_t    best_state_history [`MLSE_B_LEN-1:0];
    mlse_static_pkg::symbol_t    global_static_history [`MLSE_SH_DEPTH-1:0];
    mlse_static_pkg::branch_val_t static_val [`MLSE_B_LEN-1:0];

    // decode
    static_select_unit ssu_i (
        .state_energies     (state_energies),
        .state_histories    (state_histories),
        .best_state_energy  (best_state_energy),
        .best_state_history (best_state_history)
    );

    // execute
    conv_unit conv_i (
        .global_static_history (global_static_history),
        .est_channel           (est_channel),
        .static_val            (static_val)
    );

    // result, holds all registered state
    static_history_unit shu_i (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .best_state_energy      (best_state_energy),
        .best_state_history     (best_state_history),
        .static_val             (static_val),
        .rse_vals               (rse_vals),
        .global_static_history  (global_static_history),
        .final_symbols          (final_symbols),
        .precomputed_static_val (precomputed_static_val),
        .global_static_energy   (global_static_energy)
    );

endmodule

//--- testbench/global_static_unit_tb.sv
`timescale 1ns/1ps

`include "mlse_static_config.svh"

module global_static_unit_tb;

    // about 310 cycles of tests
    localparam int CYCLE_LIMIT = 1000;

    logic clk;
    logic rst_n;

    mlse_static_pkg::energy_t     state_energies [`MLSE_N_S-1:0];
    mlse_static_pkg::symbol_t     state_histories [`MLSE_N_S-1:0][`MLSE_B_LEN-1:0];
    mlse_static_pkg::tap_t        est_channel [`MLSE_CHAN_DEPTH-1:0];
    mlse_static_pkg::branch_val_t rse_vals [`MLSE_B_LEN-1:0];

    mlse_static_pkg::symbol_t     final_symbols [`MLSE_B_LEN-1:0];
    mlse_static_pkg::branch_val_t precomputed_static_val [`MLSE_B_LEN-1:0];
    mlse_static_pkg::energy_t     global_static_energy;

    // reference model state
    mlse_static_pkg::symbol_t     model_hist [`MLSE_SH_DEPTH-1:0];
    mlse_static_pkg::energy_t     model_energy;

    bit          check_en;
    int          test_errors;
    int          total_errors;
    int          pass_count;
    int          fail_count;
    int          cycle_count;
    int unsigned seed_draw;

    global_static_unit global_static_unit_inst (
        .clk                    (clk),
        .rst_n                  (rst_n),
        .state_energies         (state_energies),
        .state_histories        (state_histories),
        .est_channel            (est_channel),
        .rse_vals               (rse_vals),
        .final_symbols          (final_symbols),
        .precomputed_static_val (precomputed_static_val),
        .global_static_energy   (global_static_energy)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic mlse_static_pkg::symbol_t sym_from_index(int n);
        case (n % 3)
            0: return mlse_static_pkg::sym_minus;
            1: return mlse_static_pkg::sym_zero;
            default: return mlse_static_pkg::sym_plus;
        endcase
    endfunction

    function automatic mlse_static_pkg::symbol_t rand_sym();
        return sym_from_index(int'($urandom % 3));
    endfunction

    function automatic int sym_value(mlse_static_pkg::symbol_t s);
        if (s == mlse_static_pkg::sym_plus) return 1;
        if (s == mlse_static_pkg::sym_minus) return -1;
        return 0;
    endfunction

    // argmin over the current inputs, lowest index wins a tie
    function automatic int ref_select();
        int best;
        best = 0;
        for (int s = 1; s < `MLSE_N_S; s++) begin
            if (state_energies[s] < state_energies[best]) best = s;
        end
        return best;
    endfunction

    // taps against model history from slot j+B_LEN, plus rse, wrapped to B_WIDTH
    function automatic mlse_static_pkg::branch_val_t ref_static(int j);
        int acc;
        int slot;
        acc = 0;
        for (int k = 0; k < `MLSE_CHAN_DEPTH; k++) begin
            slot = j + `MLSE_B_LEN + k;
            if (slot < `MLSE_SH_DEPTH) acc += int'(est_channel[k]) * sym_value(model_hist[slot]);
        end
        acc += int'(rse_vals[j]);
        return mlse_static_pkg::branch_val_t'(acc);
    endfunction

    task automatic drive_random_states(int unsigned energy_range);
        for (int s = 0; s < `MLSE_N_S; s++) begin
            state_energies[s] <= mlse_static_pkg::energy_t'($urandom % energy_range);
            for (int b = 0; b < `MLSE_B_LEN; b++) state_histories[s][b] <= rand_sym();
        end
    endtask

    task automatic drive_random_rse();
        for (int j = 0; j < `MLSE_B_LEN; j++) begin
            rse_vals[j] <= mlse_static_pkg::branch_val_t'($urandom);
        end
    endtask

    task automatic drive_random_taps();
        for (int k = 0; k < `MLSE_CHAN_DEPTH; k++) begin
            est_channel[k] <= mlse_static_pkg::tap_t'($urandom);
        end
    endtask

    task automatic finish_test(string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: ok", name);
        end else begin
            fail_count++;
            $display("test %s: %0d mismatches", name, test_errors);
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // model follows the DUT registers at every edge
    always @(posedge clk) begin : model_update
        int sel;
        if (!rst_n) begin
            for (int i = 0; i < `MLSE_SH_DEPTH; i++) model_hist[i] = mlse_static_pkg::sym_zero;
            model_energy = '0;
        end else begin
            sel = ref_select();
            for (int i = `MLSE_SH_DEPTH - 1; i >= `MLSE_B_LEN; i--) begin
                model_hist[i] = model_hist[i - `MLSE_B_LEN];
            end
            for (int b = 0; b < `MLSE_B_LEN; b++) model_hist[b] = state_histories[sel][b];
            model_energy = state_energies[sel];
        end
    end

    // compare on the falling edge, where every output is settled
    always @(negedge clk) begin
        if (check_en) begin
            if (global_static_energy !== model_energy) begin
                $display("[FAIL] %0t global_static_energy expected %0d got %0d",
                         $time, model_energy, global_static_energy);
                test_errors++;
            end
            for (int b = 0; b < `MLSE_B_LEN; b++) begin
                if (final_symbols[b] !== model_hist[b]) begin
                    $display("[FAIL] %0t final_symbols[%0d] expected %0d got %0d",
                             $time, b, model_hist[b], final_symbols[b]);
                    test_errors++;
                end
                if (precomputed_static_val[b] !== ref_static(b)) begin
                    $display("[FAIL] %0t precomputed_static_val[%0d] expected %0d got %0d",
                             $time, b, ref_static(b), precomputed_static_val[b]);
                    test_errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $finish;
        end
    end

    initial begin
        logic [`MLSE_N_S-1:0] tie_masks [8];
        int unsigned tie_floor;

        tie_masks = '{7'b1000001, 7'b1100000, 7'b0010110, 7'b1111111,
                      7'b1000000, 7'b0000001, 7'b0101010, 7'b1010100};
        seed_draw = $urandom(60991);
        rst_n = 1'b0;
        check_en = 1'b0;
        test_errors = 0;
        total_errors = 0;
        pass_count = 0;
        fail_count = 0;
        cycle_count = 0;
        for (int s = 0; s < `MLSE_N_S; s++) begin
            state_energies[s] = '0;
            for (int b = 0; b < `MLSE_B_LEN; b++) state_histories[s][b] = mlse_static_pkg::sym_zero;
        end
        for (int k = 0; k < `MLSE_CHAN_DEPTH; k++) est_channel[k] = '0;
        for (int j = 0; j < `MLSE_B_LEN; j++) rse_vals[j] = '0;

        // reset holds for 16 edges while inputs toggle
        @(posedge clk);
        check_en = 1'b1;
        repeat (15) begin
            drive_random_states(65536);
            drive_random_rse();
            drive_random_taps();
            @(posedge clk);
        end
        rst_n <= 1'b1;
        drive_random_rse();
        @(posedge clk);
        finish_test("reset");

        // narrow energy range so ties also occur now and then
        repeat (40) begin
            drive_random_states(256);
            drive_random_rse();
            @(posedge clk);
        end
        finish_test("min_select");

        // each state gets its own symbol pair so the winner is visible
        for (int p = 0; p < 8; p++) begin
            tie_floor = $urandom % 200;
            for (int s = 0; s < `MLSE_N_S; s++) begin
                if (tie_masks[p][s]) state_energies[s] <= mlse_static_pkg::energy_t'(tie_floor);
                else state_energies[s] <= mlse_static_pkg::energy_t'(200 + $urandom % 1000);
                state_histories[s][0] <= sym_from_index(s);
                state_histories[s][1] <= sym_from_index(s / 3);
            end
            drive_random_rse();
            @(posedge clk);
        end
        finish_test("tie_break");

        for (int i = 0; i < 200; i++) begin
            if (i % 25 == 0) drive_random_taps();
            drive_random_states(65536);
            drive_random_rse();
            @(posedge clk);
        end
        finish_test("history_conv");

        // full-scale taps on an all-plus history push the sum past the limit
        for (int k = 0; k < `MLSE_CHAN_DEPTH; k++) est_channel[k] <= 8'sd127;
        repeat (40) begin
            drive_random_states(65536);
            for (int s = 0; s < `MLSE_N_S; s++) begin
                for (int b = 0; b < `MLSE_B_LEN; b++) begin
                    state_histories[s][b] <= mlse_static_pkg::sym_plus;
                end
            end
            for (int j = 0; j < `MLSE_B_LEN; j++) begin
                if ($urandom % 2 == 0) begin
                    rse_vals[j] <= mlse_static_pkg::branch_val_t'(127 - int'($urandom % 4));
                end else begin
                    rse_vals[j] <= mlse_static_pkg::branch_val_t'(-128 + int'($urandom % 4));
                end
            end
            @(posedge clk);
        end
        finish_test("wrap");

        $display("passing tests %0d, failing tests %0d, mismatches %0d",
                 pass_count, fail_count, total_errors);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- mlse_static.f
+incdir+rtl
rtl/mlse_static_pkg.sv
rtl/static_select_unit.sv
rtl/conv_unit.sv
rtl/static_history_unit.sv
rtl/global_static_unit.sv
testbench/global_static_unit_tb.sv
